//--- common/rip_cfg.svh
`ifndef RIP_CFG_SVH
`define RIP_CFG_SVH

////////////////////////////////////////////////////////////
// Execute cluster dimensions
////////////////////////////////////////////////////////////

// RV32 only. Zimm extension and mulh slices assume 32.
`define RIP_XLEN     32
`define RIP_SHAMT_W  5

// Number of ALU lanes, 2 or more.
`define RIP_LANES    4

`endif

//--- common/rip_pkg.sv
`default_nettype none

`include "rip_cfg.svh"

package rip_pkg;

    ////////////////////////////////////////////////////////////
    // Opcodes
    ////////////////////////////////////////////////////////////

    typedef enum logic [5:0] {
        OP_NOP,
        OP_ADD,
        OP_SUB,
        OP_ADDI,
        OP_SLL,
        OP_SLLI,
        OP_SLT,
        OP_SLTI,
        OP_SLTU,
        OP_SLTIU,
        OP_XOR,
        OP_XORI,
        OP_SRL,
        OP_SRLI,
        OP_SRA,
        OP_SRAI,
        OP_OR,
        OP_ORI,
        OP_AND,
        OP_ANDI,
        OP_LUI,
        OP_AUIPC,
        OP_JAL,
        OP_JALR,
        OP_LB,     // Loads and stores only form the address.
        OP_LH,
        OP_LW,
        OP_LBU,
        OP_LHU,
        OP_SB,
        OP_SH,
        OP_SW,
        OP_BEQ,    // Branches return the condition bit.
        OP_BNE,
        OP_BLT,
        OP_BGE,
        OP_BLTU,
        OP_BGEU,
        OP_CSRRW,
        OP_CSRRS,
        OP_CSRRC,
        OP_CSRRWI,
        OP_CSRRSI,
        OP_CSRRCI,
        OP_MUL,
        OP_MULH,
        OP_MULHSU,
        OP_MULHU,
        OP_DIV,
        OP_DIVU,
        OP_REM,
        OP_REMU
    } alu_op_e;

    ////////////////////////////////////////////////////////////
    // Request and response payloads
    ////////////////////////////////////////////////////////////

    typedef struct packed {
        alu_op_e                  op;
        logic [`RIP_XLEN-1:0]     rs1;
        logic [`RIP_XLEN-1:0]     rs2;
        logic [`RIP_XLEN-1:0]     pc;
        logic [`RIP_XLEN-1:0]     csr;    // Current CSR value.
        logic [`RIP_XLEN-1:0]     imm;
        logic [`RIP_SHAMT_W-1:0]  zimm;   // CSR immediate, zero-extended.
    } ex_req_t;

    typedef struct packed {
        logic [`RIP_XLEN-1:0] rslt;
    } ex_rsp_t;

endpackage : rip_pkg

`default_nettype wire

//--- rip_alu/rip_alu.sv
`default_nettype none

`include "rip_cfg.svh"

module rip_alu
    import rip_pkg::*;
(
    input  wire          clk,
    input  wire          rst_n,
    input  wire          in_valid,
    output logic         in_ready,
    input  wire ex_req_t in_req,
    output logic         out_valid,
    input  wire          out_ready,
    output ex_rsp_t      out_rsp
);

    localparam logic [`RIP_XLEN-1:0] INT_MIN = {1'b1, {(`RIP_XLEN-1){1'b0}}};

    logic [`RIP_XLEN-1:0]     a;
    logic [`RIP_XLEN-1:0]     b;
    logic [`RIP_XLEN-1:0]     zimm_ext;
    logic [`RIP_SHAMT_W-1:0]  shamt;
    logic                     accept;

    logic                     cmp_eq;
    logic                     cmp_lt;
    logic                     cmp_ltu;
    logic [`RIP_XLEN-1:0]     sum;
    logic [`RIP_XLEN-1:0]     diff;
    logic [`RIP_XLEN-1:0]     sll;
    logic [`RIP_XLEN-1:0]     srl;
    logic [`RIP_XLEN-1:0]     sra;
    logic [2*`RIP_XLEN-1:0]   mul_ss;
    logic [2*`RIP_XLEN+1:0]   mul_su;
    logic [2*`RIP_XLEN-1:0]   mul_uu;
    logic [`RIP_XLEN-1:0]     div_s;
    logic [`RIP_XLEN-1:0]     div_u;
    logic [`RIP_XLEN-1:0]     rem_s;
    logic [`RIP_XLEN-1:0]     rem_u;
    ex_rsp_t                  rsp_d;

    ////////////////////////////////////////////////////////////
    // Operand select
    ////////////////////////////////////////////////////////////

    assign zimm_ext = {{(`RIP_XLEN-`RIP_SHAMT_W){1'b0}}, in_req.zimm};
    assign shamt    = b[`RIP_SHAMT_W-1:0];

    always_comb begin
        case (in_req.op)
            OP_AUIPC, OP_JAL, OP_JALR:       a = in_req.pc;
            OP_CSRRWI, OP_CSRRSI, OP_CSRRCI: a = zimm_ext;
            default:                         a = in_req.rs1;
        endcase

        case (in_req.op)
            OP_JAL, OP_JALR: begin
                b = `RIP_XLEN'd4;            // Link address pc + 4.
            end
            OP_LUI, OP_AUIPC, OP_ADDI, OP_SLTI, OP_SLTIU, OP_XORI, OP_ORI, OP_ANDI,
            OP_SLLI, OP_SRLI, OP_SRAI,
            OP_LB, OP_LH, OP_LW, OP_LBU, OP_LHU, OP_SB, OP_SH, OP_SW: begin
                b = in_req.imm;
            end
            OP_CSRRW, OP_CSRRS, OP_CSRRC, OP_CSRRWI, OP_CSRRSI, OP_CSRRCI: begin
                b = in_req.csr;
            end
            default: begin
                b = in_req.rs2;
            end
        endcase
    end

    ////////////////////////////////////////////////////////////
    // Function units
    ////////////////////////////////////////////////////////////

    always_comb begin
        cmp_eq  = a == b;
        cmp_lt  = $signed(a) < $signed(b);
        cmp_ltu = a < b;
        sum     = a + b;
        diff    = a - b;
        sll     = a << shamt;
        srl     = a >> shamt;
        sra     = $signed(a) >>> shamt;
        mul_ss  = $signed(a) * $signed(b);
        mul_su  = $signed({a[`RIP_XLEN-1], a}) * $signed({1'b0, b});
        mul_uu  = a * b;

        if (b == '0) begin
            div_u = '1;
            rem_u = a;
        end else begin
            div_u = a / b;
            rem_u = a % b;
        end

        if (b == '0) begin
            div_s = '1;
            rem_s = a;
        end else if (a == INT_MIN && b == '1) begin
            div_s = INT_MIN;                 // Signed overflow.
            rem_s = '0;
        end else begin
            div_s = $signed(a) / $signed(b); // Truncates toward zero.
            rem_s = $signed(a) % $signed(b);
        end
    end

    always_comb begin
        case (in_req.op)
            OP_BEQ:                            rsp_d.rslt = `RIP_XLEN'(cmp_eq);
            OP_BNE:                            rsp_d.rslt = `RIP_XLEN'(!cmp_eq);
            OP_BLT, OP_SLT, OP_SLTI:           rsp_d.rslt = `RIP_XLEN'(cmp_lt);
            OP_BGE:                            rsp_d.rslt = `RIP_XLEN'(!cmp_lt);
            OP_BLTU, OP_SLTU, OP_SLTIU:        rsp_d.rslt = `RIP_XLEN'(cmp_ltu);
            OP_BGEU:                           rsp_d.rslt = `RIP_XLEN'(!cmp_ltu);
            OP_LUI:                            rsp_d.rslt = in_req.imm;
            OP_ADD, OP_ADDI, OP_AUIPC, OP_JAL, OP_JALR,
            OP_LB, OP_LH, OP_LW, OP_LBU, OP_LHU,
            OP_SB, OP_SH, OP_SW:               rsp_d.rslt = sum;
            OP_SUB:                            rsp_d.rslt = diff;
            OP_SLL, OP_SLLI:                   rsp_d.rslt = sll;
            OP_SRL, OP_SRLI:                   rsp_d.rslt = srl;
            OP_SRA, OP_SRAI:                   rsp_d.rslt = sra;
            OP_XOR, OP_XORI:                   rsp_d.rslt = a ^ b;
            OP_OR, OP_ORI, OP_CSRRS, OP_CSRRSI: rsp_d.rslt = a | b;
            OP_AND, OP_ANDI:                   rsp_d.rslt = a & b;
            OP_CSRRW, OP_CSRRWI:               rsp_d.rslt = a;
            OP_CSRRC, OP_CSRRCI:               rsp_d.rslt = ~a & b;
            OP_MUL:                            rsp_d.rslt = mul_uu[`RIP_XLEN-1:0];
            OP_MULH:                           rsp_d.rslt = mul_ss[2*`RIP_XLEN-1:`RIP_XLEN];
            OP_MULHSU:                         rsp_d.rslt = mul_su[2*`RIP_XLEN-1:`RIP_XLEN];
            OP_MULHU:                          rsp_d.rslt = mul_uu[2*`RIP_XLEN-1:`RIP_XLEN];
            OP_DIV:                            rsp_d.rslt = div_s;
            OP_DIVU:                           rsp_d.rslt = div_u;
            OP_REM:                            rsp_d.rslt = rem_s;
            OP_REMU:                           rsp_d.rslt = rem_u;
            default:                           rsp_d.rslt = '0;  // NOP.
        endcase
    end

    ////////////////////////////////////////////////////////////
    // One-entry result register
    ////////////////////////////////////////////////////////////

    // Accept when empty or being drained this cycle.
    assign in_ready = !out_valid || out_ready;
    assign accept   = in_valid && in_ready;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            out_valid <= 1'b0;
        end else if (accept) begin
            out_valid <= 1'b1;
        end else if (out_ready) begin
            out_valid <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            out_rsp <= rsp_d;
        end
    end

endmodule : rip_alu

`default_nettype wire

//--- design/rip_dispatch.sv
`default_nettype none

`include "rip_cfg.svh"

module rip_dispatch
    import rip_pkg::*;
(
    input  wire                    clk,
    input  wire                    rst_n,
    input  wire                    in_valid,
    output logic                   in_ready,
    input  wire ex_req_t           in_req,
    output logic [`RIP_LANES-1:0]  lane_in_valid,
    input  wire  [`RIP_LANES-1:0]  lane_in_ready,
    output ex_req_t                lane_in_req
);

    localparam int PTR_W = $clog2(`RIP_LANES);

    logic [PTR_W-1:0] ptr;

    ////////////////////////////////////////////////////////////
    // Steering to the pointed lane
    ////////////////////////////////////////////////////////////

    always_comb begin
        lane_in_valid      = '0;
        lane_in_valid[ptr] = in_valid;
    end

    assign in_ready    = lane_in_ready[ptr];  // Busy lane stalls input.
    assign lane_in_req = in_req;              // Shared, qualified by valid.

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            ptr <= '0;
        end else if (in_valid && in_ready) begin
            if (ptr == PTR_W'(`RIP_LANES-1)) begin
                ptr <= '0;
            end else begin
                ptr <= ptr + 1'b1;
            end
        end
    end

endmodule : rip_dispatch

`default_nettype wire

//--- design/rip_retire.sv
`default_nettype none

`include "rip_cfg.svh"

module rip_retire
    import rip_pkg::*;
(
    input  wire                             clk,
    input  wire                             rst_n,
    input  wire  [`RIP_LANES-1:0]           lane_out_valid,
    output logic [`RIP_LANES-1:0]           lane_out_ready,
    input  wire ex_rsp_t [`RIP_LANES-1:0]   lane_out_rsp,
    output logic                            out_valid,
    input  wire                             out_ready,
    output ex_rsp_t                         out_rsp
);

    localparam int PTR_W = $clog2(`RIP_LANES);

    logic [PTR_W-1:0] ptr;

    ////////////////////////////////////////////////////////////
    // In-order drain
    ////////////////////////////////////////////////////////////

    // Only the pointed lane sees out_ready, others keep their result.
    always_comb begin
        lane_out_ready      = '0;
        lane_out_ready[ptr] = out_ready;
    end

    assign out_valid = lane_out_valid[ptr];
    assign out_rsp   = lane_out_rsp[ptr];

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            ptr <= '0;                           // Matches dispatch start.
        end else if (out_valid && out_ready) begin
            if (ptr == PTR_W'(`RIP_LANES-1)) begin
                ptr <= '0;
            end else begin
                ptr <= ptr + 1'b1;
            end
        end
    end

endmodule : rip_retire

`default_nettype wire

//--- design/rip_ex_cluster.sv
`default_nettype none

`include "rip_cfg.svh"

module rip_ex_cluster
    import rip_pkg::*;
(
    input  wire           clk,
    input  wire           rst_n,
    input  wire           in_valid,
    output logic          in_ready,
    input  wire ex_req_t  in_req,
    output logic          out_valid,
    input  wire           out_ready,
    output ex_rsp_t       out_rsp
);

    logic [`RIP_LANES-1:0]    lane_in_valid;
    logic [`RIP_LANES-1:0]    lane_in_ready;
    ex_req_t                  lane_in_req;
    logic [`RIP_LANES-1:0]    lane_out_valid;
    logic [`RIP_LANES-1:0]    lane_out_ready;
    ex_rsp_t [`RIP_LANES-1:0] lane_out_rsp;

    ////////////////////////////////////////////////////////////
    // Dispatch, lanes, retire
    ////////////////////////////////////////////////////////////

    rip_dispatch u_dispatch (
        .clk           (clk),
        .rst_n         (rst_n),
        .in_valid      (in_valid),
        .in_ready      (in_ready),
        .in_req        (in_req),
        .lane_in_valid (lane_in_valid),
        .lane_in_ready (lane_in_ready),
        .lane_in_req   (lane_in_req)
    );

    for (genvar i = 0; i < `RIP_LANES; i++) begin : g_lane
        rip_alu u_alu (
            .clk       (clk),
            .rst_n     (rst_n),
            .in_valid  (lane_in_valid[i]),
            .in_ready  (lane_in_ready[i]),
            .in_req    (lane_in_req),
            .out_valid (lane_out_valid[i]),
            .out_ready (lane_out_ready[i]),
            .out_rsp   (lane_out_rsp[i])
        );
    end

    rip_retire u_retire (
        .clk            (clk),
        .rst_n          (rst_n),
        .lane_out_valid (lane_out_valid),
        .lane_out_ready (lane_out_ready),
        .lane_out_rsp   (lane_out_rsp),
        .out_valid      (out_valid),
        .out_ready      (out_ready),
        .out_rsp        (out_rsp)
    );

endmodule : rip_ex_cluster

`default_nettype wire

//--- tb/rip_ex_assert.sv
`default_nettype none

`include "rip_cfg.svh"

module rip_ex_assert
    import rip_pkg::*;
(
    input wire          clk,
    input wire          rst_n,
    input wire          in_valid,
    input wire          in_ready,
    input wire ex_req_t in_req,
    input wire          out_valid,
    input wire          out_ready,
    input wire ex_rsp_t out_rsp
);

    int unsigned fail_count = 0;

    ////////////////////////////////////////////////////////////
    // Handshake protocol
    ////////////////////////////////////////////////////////////

    a_reset_state: assert property (@(posedge clk) !rst_n |=> !out_valid && in_ready)
        else begin
            fail_count++;
            $error("Output valid or input not ready after reset.");
        end

    a_out_hold: assert property (@(posedge clk) disable iff (!rst_n)
        out_valid && !out_ready |=> out_valid && $stable(out_rsp))
        else begin
            fail_count++;
            $error("Stalled result changed before transfer.");
        end

    a_req_known: assert property (@(posedge clk) disable iff (!rst_n)
        in_valid |-> !$isunknown(in_req))
        else begin
            fail_count++;
            $error("Unknown bits in a valid request.");
        end

    a_rsp_known: assert property (@(posedge clk) disable iff (!rst_n)
        out_valid |-> !$isunknown(out_rsp))
        else begin
            fail_count++;
            $error("Unknown bits in a valid result.");
        end

endmodule

bind rip_ex_cluster rip_ex_assert u_assert (.*);

`default_nettype wire

//--- tb/rip_ex_tb.sv
`default_nettype none

`include "rip_cfg.svh"

module rip_ex_tb
    import rip_pkg::*;
();

    localparam int TIMEOUT    = 100;  // Cycles per wait.
    localparam int NUM_RANDOM = 300;

    logic                  clk;
    logic                  rst_n;
    logic                  in_valid;
    logic                  in_ready;
    ex_req_t               in_req;
    logic                  out_valid;
    logic                  out_ready;
    ex_rsp_t               out_rsp;

    logic [31:0]           lfsr;
    logic                  ready_random;     // Toggle out_ready from the LFSR.
    logic [`RIP_XLEN-1:0]  exp_q[$];
    logic [`RIP_XLEN-1:0]  exp_val;
    int                    acc_count;
    int                    ret_count;
    int                    err_count;
    int                    timeout_count;
    int                    total;
    ex_req_t               held_req;

    rip_ex_cluster UUT (.*);

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    ////////////////////////////////////////////////////////////
    // Stimulus and reference model
    ////////////////////////////////////////////////////////////

    // Taps 32, 22, 2, 1.
    function automatic logic [31:0] take_bits(input int n);
        logic [31:0] v;
        logic        fb;
        int          i;
        v = '0;
        for (i = 0; i < n; i++) begin
            fb   = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
            lfsr = {lfsr[30:0], fb};
            v    = {v[30:0], fb};
        end
        return v;
    endfunction

    function automatic ex_req_t rand_req();
        ex_req_t r;
        r.op  = alu_op_e'(take_bits(6) % (int'(OP_REMU) + 1));
        r.rs1 = take_bits(32);
        case (take_bits(2))
            0:       r.rs2 = r.rs1;          // Equal operands for branches.
            1:       r.rs2 = take_bits(3);   // Small, sometimes zero.
            default: r.rs2 = take_bits(32);
        endcase
        r.pc   = take_bits(32);
        r.csr  = take_bits(32);
        r.imm  = take_bits(32);
        r.zimm = 5'(take_bits(5));
        return r;
    endfunction

    function automatic ex_req_t build_req(input alu_op_e op, input logic [31:0] x, y);
        ex_req_t r;
        r = '{op: op, rs1: x, rs2: y, pc: x, csr: y, imm: y, zimm: x[4:0]};
        return r;
    endfunction

    function automatic logic [`RIP_XLEN-1:0] expected_rslt(input ex_req_t r);
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] y;
        logic [63:0] p;
        logic        ovf;
        if (r.op inside {OP_AUIPC, OP_JAL, OP_JALR}) a = r.pc;
        else if (r.op inside {OP_CSRRWI, OP_CSRRSI, OP_CSRRCI}) a = {27'd0, r.zimm};
        else a = r.rs1;
        if (r.op inside {OP_JAL, OP_JALR}) b = 32'd4;
        else if (r.op inside {OP_LUI, OP_AUIPC, OP_ADDI, OP_SLTI, OP_SLTIU, OP_XORI, OP_ORI,
                              OP_ANDI, OP_SLLI, OP_SRLI, OP_SRAI, OP_LB, OP_LH, OP_LW,
                              OP_LBU, OP_LHU, OP_SB, OP_SH, OP_SW}) b = r.imm;
        else if (r.op inside {OP_CSRRW, OP_CSRRS, OP_CSRRC,
                              OP_CSRRWI, OP_CSRRSI, OP_CSRRCI}) b = r.csr;
        else b = r.rs2;
        ovf = (a == 32'h8000_0000) && (b == 32'hffff_ffff);
        case (r.op)
            OP_SUB:                      y = a - b;
            OP_SLL, OP_SLLI:             y = a << b[4:0];
            OP_SRL, OP_SRLI:             y = a >> b[4:0];
            OP_SRA, OP_SRAI:             y = $signed(a) >>> b[4:0];
            OP_SLT, OP_SLTI, OP_BLT:     y = {31'd0, $signed(a) < $signed(b)};
            OP_SLTU, OP_SLTIU, OP_BLTU:  y = {31'd0, a < b};
            OP_BGE:                      y = {31'd0, $signed(a) >= $signed(b)};
            OP_BGEU:                     y = {31'd0, a >= b};
            OP_BEQ:                      y = {31'd0, a == b};
            OP_BNE:                      y = {31'd0, a != b};
            OP_XOR, OP_XORI:             y = a ^ b;
            OP_OR, OP_ORI:               y = a | b;
            OP_AND, OP_ANDI:             y = a & b;
            OP_LUI:                      y = r.imm;
            OP_CSRRW, OP_CSRRWI:         y = a;
            OP_CSRRS, OP_CSRRSI:         y = b | a;
            OP_CSRRC, OP_CSRRCI:         y = b & ~a;
            OP_MUL, OP_MULHU: begin
                p = {32'd0, a} * {32'd0, b};
                y = (r.op == OP_MUL) ? p[31:0] : p[63:32];
            end
            OP_MULH: begin
                p = {{32{a[31]}}, a} * {{32{b[31]}}, b};
                y = p[63:32];
            end
            OP_MULHSU: begin
                p = {{32{a[31]}}, a} * {32'd0, b};
                y = p[63:32];
            end
            OP_DIV:   y = (b == 0) ? '1 : ovf ? a : 32'($signed(a) / $signed(b));
            OP_REM:   y = (b == 0) ? a : ovf ? '0 : 32'($signed(a) % $signed(b));
            OP_DIVU:  y = (b == 0) ? '1 : a / b;
            OP_REMU:  y = (b == 0) ? a : a % b;
            OP_NOP:   y = '0;
            default:  y = a + b;             // Add, address and link forms.
        endcase
        return y;
    endfunction

    task automatic next_cycle();
        @(negedge clk);
        if (ready_random) out_ready = (take_bits(1) != 0);
    endtask

    task automatic send(input ex_req_t r);
        int n0;
        int waited;
        n0       = acc_count;
        waited   = 0;
        in_req   = r;
        in_valid = 1'b1;
        next_cycle();
        while (acc_count == n0 && waited < TIMEOUT) begin
            waited++;
            next_cycle();
        end
        if (acc_count == n0) begin
            timeout_count++;
            $display("Timeout at %0t: the input never became ready", $time);
        end
        in_valid = 1'b0;
    endtask

    task automatic wait_drain();
        int waited;
        waited       = 0;
        ready_random = 1'b0;
        out_ready    = 1'b1;
        while (exp_q.size() != 0 && waited < TIMEOUT) begin
            waited++;
            @(negedge clk);
        end
        if (exp_q.size() != 0) begin
            timeout_count++;
            $display("Timeout at %0t: the output never became valid for %0d results",
                     $time, exp_q.size());
        end
    endtask

    ////////////////////////////////////////////////////////////
    // Scoreboard
    ////////////////////////////////////////////////////////////

    always @(posedge clk) begin
        if (rst_n) begin
            if (out_valid && out_ready) begin
                ret_count++;
                assert (exp_q.size() > 0) else begin
                    err_count++;
                    $display("Result at %0t arrived with no request outstanding", $time);
                end
                if (exp_q.size() > 0) begin
                    exp_val = exp_q.pop_front();
                    assert (out_rsp.rslt == exp_val) else begin
                        err_count++;
                        $display("ERROR at %0t: out_rsp.rslt expected %08h actual %08h",
                                 $time, exp_val, out_rsp.rslt);
                    end
                end
            end
            if (in_valid && in_ready) begin
                exp_q.push_back(expected_rslt(in_req));
                acc_count++;
            end
        end
    end

    ////////////////////////////////////////////////////////////
    // Test sequence
    ////////////////////////////////////////////////////////////

    initial begin
        lfsr          = 32'hd4fb6a49;
        acc_count     = 0;
        ret_count     = 0;
        err_count     = 0;
        timeout_count = 0;
        ready_random  = 1'b0;
        rst_n         = 1'b0;
        in_valid      = 1'b0;
        in_req        = '0;
        out_ready     = 1'b0;
        repeat (2) @(negedge clk);
        rst_n        = 1'b1;
        ready_random = 1'b1;

        send(build_req(OP_DIV, 32'h1234_5678, 32'd0));
        send(build_req(OP_DIVU, 32'h8765_4321, 32'd0));
        send(build_req(OP_REM, 32'h1234_5678, 32'd0));
        send(build_req(OP_REMU, 32'h8765_4321, 32'd0));
        send(build_req(OP_DIV, 32'h8000_0000, 32'hffff_ffff));
        send(build_req(OP_REM, 32'h8000_0000, 32'hffff_ffff));
        send(build_req(OP_DIV, 32'hffff_fff9, 32'd2));         // -7 / 2.
        send(build_req(OP_REM, 32'hffff_fff9, 32'd2));
        send(build_req(OP_MULH, 32'h8000_0000, 32'h8000_0000));
        send(build_req(OP_MULHSU, 32'hffff_ffff, 32'hffff_ffff));
        send(build_req(OP_MULHU, 32'hffff_ffff, 32'hffff_ffff));
        send(build_req(OP_SLL, 32'h0000_00f1, 32'h0000_0123));  // Only low 5 bits shift.
        send(build_req(OP_SRAI, 32'h8000_0010, 32'hffff_ffe4));
        send(build_req(OP_LUI, 32'h0, 32'habcd_e000));
        send(build_req(OP_AUIPC, 32'h0000_1000, 32'h0002_0000));
        send(build_req(OP_JAL, 32'h0000_0ffc, 32'h0));
        send(build_req(OP_JALR, 32'hffff_fffc, 32'h0));
        send(build_req(OP_CSRRW, 32'h5a5a_0f0f, 32'h00ff_00ff));
        send(build_req(OP_CSRRS, 32'h5a5a_0f0f, 32'h00ff_00ff));
        send(build_req(OP_CSRRC, 32'h5a5a_0f0f, 32'h00ff_00ff));
        send(build_req(OP_CSRRWI, 32'h0000_001f, 32'hf0f0_0000));
        send(build_req(OP_CSRRSI, 32'h0000_0015, 32'hf0f0_0000));
        send(build_req(OP_CSRRCI, 32'h0000_001b, 32'hffff_ffff));

        repeat (NUM_RANDOM) begin
            send(rand_req());
            if (take_bits(2) == 0) next_cycle();
        end
        wait_drain();

        // Output stalled, one result per lane, then input must stall.
        out_ready = 1'b0;
        repeat (`RIP_LANES) begin
            assert (in_ready) else begin
                err_count++;
                $display("Input stalled at %0t before every lane held a result", $time);
            end
            send(rand_req());
        end
        held_req = rand_req();
        in_req   = held_req;
        in_valid = 1'b1;
        repeat (3) begin
            assert (!in_ready) else begin
                err_count++;
                $display("Input still ready at %0t with every lane full", $time);
            end
            next_cycle();
        end
        out_ready = 1'b1;
        send(held_req);
        wait_drain();

        assert (exp_q.size() == 0 && acc_count == ret_count) else begin
            err_count++;
            $display("Accepted %0d requests but returned %0d results", acc_count, ret_count);
        end
        total = err_count + timeout_count + UUT.u_assert.fail_count;
        $display("Accepted %0d, returned %0d, errors %0d, timeouts %0d, assertion failures %0d",
                 acc_count, ret_count, err_count, timeout_count, UUT.u_assert.fail_count);
        if (total == 0) begin
            $display("All tests passed!");
        end else begin
            $display("Test failures found");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- tb.f
+incdir+common
common/rip_pkg.sv
rip_alu/rip_alu.sv
design/rip_dispatch.sv
design/rip_retire.sv
design/rip_ex_cluster.sv
tb/rip_ex_assert.sv
tb/rip_ex_tb.sv

//--- Bender.yml
package:
  name: rip_ex_cluster

export_include_dirs:
  - common

sources:
  - common/rip_pkg.sv
  - rip_alu/rip_alu.sv
  - design/rip_dispatch.sv
  - design/rip_retire.sv
  - design/rip_ex_cluster.sv
  - target: test
    files:
      - tb/rip_ex_assert.sv
      - tb/rip_ex_tb.sv
